// ==== source/displayTypesPkg.sv ====
/*
 * Display bus types and panel init sequence
 * Bus word carried to the 8080 writer, the shortened ILI9486 power-up
 * table in portrait and landscape form, and the strobe divider width
 */
package displayTypesPkg;

    localparam int initLength = 14;
    localparam int clockDivWidth = 6;

    // One byte on the panel bus, isData is the dc level
    typedef struct packed {
        logic       isData;
        logic [7:0] value;
    } busWord_t;

    // Portrait uses MADCTL 0x98, columns end at 319 and pages at 479
    localparam busWord_t initTablePortrait [initLength] = '{
        '{1'b0, 8'h11},
        '{1'b0, 8'h36},
        '{1'b1, 8'h98},
        '{1'b0, 8'h2A},
        '{1'b1, 8'h00},
        '{1'b1, 8'h00},
        '{1'b1, 8'h01},
        '{1'b1, 8'h3F},
        '{1'b0, 8'h2B},
        '{1'b1, 8'h00},
        '{1'b1, 8'h00},
        '{1'b1, 8'h01},
        '{1'b1, 8'hDF},
        '{1'b0, 8'h2C}
    };

    // Landscape swaps the end bytes and flips the scan direction
    localparam busWord_t initTableLandscape [initLength] = '{
        '{1'b0, 8'h11},
        '{1'b0, 8'h36},
        '{1'b1, 8'hB8},
        '{1'b0, 8'h2A},
        '{1'b1, 8'h00},
        '{1'b1, 8'h00},
        '{1'b1, 8'h01},
        '{1'b1, 8'hDF},
        '{1'b0, 8'h2B},
        '{1'b1, 8'h00},
        '{1'b1, 8'h00},
        '{1'b1, 8'h01},
        '{1'b1, 8'h3F},
        '{1'b0, 8'h2C}
    };

endpackage

// ==== source/pixelTypesPkg.sv ====
/*
 * Pixel types
 * Incoming 16-bit pixel word, the supported input formats and the
 * panel's RGB565 layout with its field widths
 */
package pixelTypesPkg;

    localparam int pixelWidth = 16;

    // Panel field widths, red is most significant
    localparam int redWidth = 5;
    localparam int greenWidth = 6;
    localparam int blueWidth = 5;

    // RGBA4444 nibble positions, alpha sits in the lowest nibble
    localparam int nibbleWidth = 4;
    localparam int redNibbleLsb = 12;
    localparam int greenNibbleLsb = 8;
    localparam int blueNibbleLsb = 4;

    typedef logic [pixelWidth-1:0] pixelIn_t;

    typedef enum logic {
        formatRgb565Reversed,
        formatRgba4444
    } pixelFormat_t;

    typedef struct packed {
        logic [redWidth-1:0]   red;
        logic [greenWidth-1:0] green;
        logic [blueWidth-1:0]  blue;
    } panelPixel_t;

endpackage

// ==== source/streamSlice.sv ====
/*
 * Stream register slice
 * Two-entry skid buffer on a valid/ready link; both ready and the
 * output are registered, one word per cycle when the link flows
 */
`timescale 1ns/1ps

module streamSlice #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     aclk,
    input  logic     resetn,
    input  logic     inValid,
    output logic     inReady,
    input  payload_t inData,
    output logic     outValid,
    input  logic     outReady,
    output payload_t outData
);
    payload_t skidData;
    logic     skidValid;
    logic     inAccept;
    logic     outFree;
    logic     skidNext;

    assign inAccept = inValid && inReady;
    assign outFree = !outValid || outReady;

    // Skid entry fills when the output stalls and drains when it moves
    always_comb
    begin
        if (outFree)
            skidNext = 1'b0;
        else
            skidNext = skidValid || inAccept;
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            outValid <= 1'b0;
            skidValid <= 1'b0;
            inReady <= 1'b0;
        end
        else
        begin
            skidValid <= skidNext;
            inReady <= !skidNext;
            if (outFree)
                outValid <= skidValid || inAccept;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (outFree)
            outData <= skidValid ? skidData : inData;
        if (!outFree && inAccept)
            skidData <= inData;
    end

endmodule

// ==== source/pixelConverter.sv ====
/*
 * Pixel format converter
 * Maps each incoming pixel to panel RGB565 using the selected format,
 * result registered with one cycle of latency
 */
`timescale 1ns/1ps

module pixelConverter (
    input  logic                        aclk,
    input  logic                        resetn,
    input  pixelTypesPkg::pixelFormat_t format,
    input  logic                        inValid,
    output logic                        inReady,
    input  pixelTypesPkg::pixelIn_t     inPixel,
    output logic                        outValid,
    input  logic                        outReady,
    output pixelTypesPkg::panelPixel_t  outPixel
);
    import pixelTypesPkg::*;

    panelPixel_t converted;

    always_comb
    begin
        if (format == formatRgba4444)
        begin
            // Nibble to the top of each field, alpha dropped
            converted.red = {inPixel[redNibbleLsb +: nibbleWidth],
                             {(redWidth - nibbleWidth){1'b0}}};
            converted.green = {inPixel[greenNibbleLsb +: nibbleWidth],
                               {(greenWidth - nibbleWidth){1'b0}}};
            converted.blue = {inPixel[blueNibbleLsb +: nibbleWidth],
                              {(blueWidth - nibbleWidth){1'b0}}};
        end
        else
        begin
            // Red arrives in the low bits
            converted.red = inPixel[0 +: redWidth];
            converted.green = inPixel[redWidth +: greenWidth];
            converted.blue = inPixel[redWidth + greenWidth +: blueWidth];
        end
    end

    assign inReady = !outValid || outReady;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
            outValid <= 1'b0;
        else if (inReady)
            outValid <= inValid;
    end

    always_ff @(posedge aclk)
    begin
        if (inValid && inReady)
            outPixel <= converted;
    end

endmodule

// ==== source/commandSequencer.sv ====
/*
 * Command sequencer
 * Sends the panel init table once after reset, then splits every
 * RGB565 pixel into a high and a low data byte
 */
`timescale 1ns/1ps

module commandSequencer #(
    parameter bit landscape = 1'b0
) (
    input  logic                       aclk,
    input  logic                       resetn,
    input  logic                       pixValid,
    output logic                       pixReady,
    input  pixelTypesPkg::panelPixel_t pixData,
    output logic                       wordValid,
    input  logic                       wordReady,
    output displayTypesPkg::busWord_t  word
);
    import displayTypesPkg::*;

    localparam int indexWidth = $clog2(initLength);

    // State names the next word to be loaded into the output register
    typedef enum logic [1:0] {
        stateInit,
        stateHighByte,
        stateLowByte
    } state_t;

    state_t                state;
    logic [indexWidth-1:0] initIndex;
    logic [7:0]            lowByte;
    logic                  wordFree;
    busWord_t              tableWord;

    assign wordFree = !wordValid || wordReady;
    assign pixReady = (state == stateHighByte) && wordFree;

    always_comb
    begin
        if (landscape)
            tableWord = initTableLandscape[initIndex];
        else
            tableWord = initTablePortrait[initIndex];
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state <= stateInit;
            initIndex <= '0;
            wordValid <= 1'b0;
        end
        else
        begin
            case (state)
                stateInit:
                begin
                    if (wordFree)
                    begin
                        wordValid <= 1'b1;
                        initIndex <= initIndex + 1'b1;
                        if (initIndex == indexWidth'(initLength - 1))
                            state <= stateHighByte;
                    end
                end
                stateHighByte:
                begin
                    if (pixValid && wordFree)
                    begin
                        wordValid <= 1'b1;
                        state <= stateLowByte;
                    end
                    else if (wordReady)
                    begin
                        wordValid <= 1'b0;
                    end
                end
                default:
                begin
                    // Low byte follows once the high byte has gone
                    if (wordFree)
                    begin
                        wordValid <= 1'b1;
                        state <= stateHighByte;
                    end
                end
            endcase
        end
    end

    // The packed pixel is already the RGB565 word, red on top
    always_ff @(posedge aclk)
    begin
        if (state == stateInit && wordFree)
            word <= tableWord;
        else if (pixReady && pixValid)
        begin
            word <= '{isData: 1'b1, value: pixData[15:8]};
            lowByte <= pixData[7:0];
        end
        else if (state == stateLowByte && wordFree)
            word <= '{isData: 1'b1, value: lowByte};
    end

endmodule

// ==== source/parallelBusWriter.sv ====
/*
 * 8080 parallel bus writer
 * Puts one bus word per wr strobe on data and dc; the low and high
 * phases of wr each last clockDiv+1 cycles
 */
`timescale 1ns/1ps

module parallelBusWriter #(
    parameter int unsigned clockDiv = 1
) (
    input  logic                      aclk,
    input  logic                      resetn,
    input  logic                      wordValid,
    output logic                      wordReady,
    input  displayTypesPkg::busWord_t word,
    output logic [7:0]                data,
    output logic                      dc,
    output logic                      cs,
    output logic                      wr
);
    import displayTypesPkg::*;

    typedef enum logic [1:0] {
        stateIdle,
        stateStrobeLow,
        stateStrobeHigh
    } state_t;

    state_t                   state;
    logic [clockDivWidth-1:0] divCount;
    logic                     divDone;

    assign divDone = (divCount == clockDivWidth'(clockDiv));

    // Last high cycle counts as idle so strobes run back to back
    assign wordReady = (state == stateIdle) || (state == stateStrobeHigh && divDone);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state <= stateIdle;
            divCount <= '0;
            data <= 8'h00;
            dc <= 1'b1;
            cs <= 1'b1;
            wr <= 1'b1;
        end
        else
        begin
            cs <= 1'b0;
            divCount <= divDone ? '0 : divCount + 1'b1;
            if (wordReady)
            begin
                divCount <= '0;
                if (wordValid)
                begin
                    data <= word.value;
                    dc <= word.isData;
                    wr <= 1'b0;
                    state <= stateStrobeLow;
                end
                else
                begin
                    state <= stateIdle;
                end
            end
            else if (state == stateStrobeLow && divDone)
            begin
                // Panel samples data and dc on this rising edge
                wr <= 1'b1;
                state <= stateStrobeHigh;
            end
        end
    end

endmodule

// ==== source/displayController.sv ====
/*
 * ILI9486 display controller
 * Pixel stream in, 8080 bus out: input slice, format converter,
 * second slice, command sequencer and strobe writer
 */
`timescale 1ns/1ps

module displayController #(
    parameter int unsigned clockDiv = 1,
    parameter bit          landscape = 1'b0
) (
    input  logic                        aclk,
    input  logic                        resetn,
    input  pixelTypesPkg::pixelFormat_t format,
    input  logic                        sValid,
    output logic                        sReady,
    input  pixelTypesPkg::pixelIn_t     sPixel,
    output logic [7:0]                  data,
    output logic                        dc,
    output logic                        cs,
    output logic                        wr
);
    import pixelTypesPkg::*;
    import displayTypesPkg::*;

    pixelIn_t    rawPixel;
    logic        rawValid;
    logic        rawReady;
    panelPixel_t convPixel;
    logic        convValid;
    logic        convReady;
    panelPixel_t seqPixel;
    logic        seqValid;
    logic        seqReady;
    busWord_t    busWord;
    logic        busValid;
    logic        busReady;

    streamSlice #(.payload_t(pixelIn_t)) inputSlice (
        .aclk(aclk), .resetn(resetn),
        .inValid(sValid), .inReady(sReady), .inData(sPixel),
        .outValid(rawValid), .outReady(rawReady), .outData(rawPixel)
    );

    pixelConverter converter (
        .aclk(aclk), .resetn(resetn), .format(format),
        .inValid(rawValid), .inReady(rawReady), .inPixel(rawPixel),
        .outValid(convValid), .outReady(convReady), .outPixel(convPixel)
    );

    streamSlice #(.payload_t(panelPixel_t)) panelSlice (
        .aclk(aclk), .resetn(resetn),
        .inValid(convValid), .inReady(convReady), .inData(convPixel),
        .outValid(seqValid), .outReady(seqReady), .outData(seqPixel)
    );

    commandSequencer #(.landscape(landscape)) sequencer (
        .aclk(aclk), .resetn(resetn),
        .pixValid(seqValid), .pixReady(seqReady), .pixData(seqPixel),
        .wordValid(busValid), .wordReady(busReady), .word(busWord)
    );

    parallelBusWriter #(.clockDiv(clockDiv)) writer (
        .aclk(aclk), .resetn(resetn),
        .wordValid(busValid), .wordReady(busReady), .word(busWord),
        .data(data), .dc(dc), .cs(cs), .wr(wr)
    );

endmodule

// ==== verif/tbChecks.svh ====
/*
 * Testbench compare tasks
 * One check per result kind; each mismatch is counted and printed
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic compareWord(input string name, input busWord_t got, input busWord_t expected);
    if (got !== expected)
    begin
        errorCount++;
        $display("Error %s: got 0x%h expected 0x%h", name, got, expected);
    end
endtask

task automatic comparePixel(input string name, input panelPixel_t got,
                            input panelPixel_t expected);
    if (got !== expected)
    begin
        errorCount++;
        $display("Error %s: got 0x%h expected 0x%h", name, got, expected);
    end
endtask

task automatic compareCount(input string name, input int got, input int expected);
    if (got != expected)
    begin
        errorCount++;
        $display("Error %s: got 0x%0h expected 0x%0h", name, got, expected);
    end
endtask

task automatic compareBit(input string name, input logic got, input logic expected);
    if (got !== expected)
    begin
        errorCount++;
        $display("Error %s: got 0x%h expected 0x%h", name, got, expected);
    end
endtask

`endif

// ==== verif/displayControllerTb.sv ====
/*
 * Display controller testbench
 * Streams pixels into the controller, captures every byte written on
 * the 8080 bus and checks the init sequence, both formats and timing
 */
`timescale 1ns/1ps

module displayControllerTb;
    import displayTypesPkg::*;
    import pixelTypesPkg::*;

    localparam int tbClockDiv = 1;
    localparam int strobePhase = tbClockDiv + 1;
    localparam int bytePeriod = 2 * strobePhase;
    localparam int waitLimit = 2000;

    logic         aclk;
    logic         resetn;
    pixelFormat_t format;
    logic         sValid;
    logic         sReady;
    pixelIn_t     sPixel;
    logic [7:0]   data;
    logic         dc;
    logic         cs;
    logic         wr;

    busWord_t     captured[$];
    int           lowLength[$];
    int           fallGap[$];
    panelPixel_t  expectedPixels[$];
    int           errorCount;
    int           testsPassed;
    int           testsFailed;
    int unsigned  lcgState;
    logic         stallSeen;
    int           cycleCount = 0;
    int           lastFall = -1;
    logic         lastWr = 1'b1;
    int           csHighStrobes = 0;

    `include "tbChecks.svh"

    displayController #(.clockDiv(tbClockDiv), .landscape(1'b0)) UUT (
        .aclk(aclk), .resetn(resetn), .format(format),
        .sValid(sValid), .sReady(sReady), .sPixel(sPixel),
        .data(data), .dc(dc), .cs(cs), .wr(wr)
    );

    always #5 aclk = ~aclk;

    // Capture each written byte at the falling edge where the outputs are stable
    always @(negedge aclk)
    begin
        cycleCount++;
        if (lastWr && !wr)
        begin
            if (cs)
                csHighStrobes++;
            if (lastFall >= 0)
                fallGap.push_back(cycleCount - lastFall);
            lastFall = cycleCount;
        end
        if (!lastWr && wr)
        begin
            captured.push_back(busWord_t'{isData: dc, value: data});
            lowLength.push_back(cycleCount - lastFall);
        end
        lastWr = wr;
    end

    function automatic pixelIn_t nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15];
    endfunction

    // Reference conversion rules for both input formats
    function automatic panelPixel_t expectPixel(input pixelFormat_t fmt, input pixelIn_t pix);
        panelPixel_t result;
        if (fmt == formatRgba4444)
        begin
            result.red = {pix[15:12], 1'b0};
            result.green = {pix[11:8], 2'b00};
            result.blue = {pix[7:4], 1'b0};
        end
        else
        begin
            result.red = pix[4:0];
            result.green = pix[10:5];
            result.blue = pix[15:11];
        end
        return result;
    endfunction

    // Rebuilds pixel n of the stream from its high and low bus bytes
    function automatic panelPixel_t capturedPixel(input int index);
        panelPixel_t result;
        int          w;
        w = initLength + 2 * index;
        result = {captured[w].value, captured[w + 1].value};
        return result;
    endfunction

    task automatic timeoutFail(input string what);
        $display("Timeout: %s", what);
        $display("TB FAILED");
        $finish;
    endtask

    // Called on a falling edge; returns on the falling edge after the transfer
    task automatic sendPixel(input pixelIn_t pix);
        int waitCount;
        sValid = 1'b1;
        sPixel = pix;
        waitCount = 0;
        while (!sReady && waitCount < waitLimit)
        begin
            stallSeen = 1'b1;
            @(negedge aclk);
            waitCount++;
        end
        if (!sReady)
            timeoutFail("sReady never rose for an offered pixel");
        else
        begin
            expectedPixels.push_back(expectPixel(format, pix));
            @(negedge aclk);
        end
    endtask

    task automatic waitForBytes(input int count);
        int waitCount;
        waitCount = 0;
        while (captured.size() < count && waitCount < waitLimit)
        begin
            @(posedge aclk);
            waitCount++;
        end
        if (captured.size() < count)
            timeoutFail("expected bytes never appeared on the panel bus");
        else
            @(negedge aclk);
    endtask

    task automatic checkPixels(input int first, input int count);
        int k;
        int w;
        waitForBytes(initLength + 2 * (first + count));
        for (k = first; k < first + count; k++)
        begin
            w = initLength + 2 * k;
            compareBit("dc of high byte", captured[w].isData, 1'b1);
            compareBit("dc of low byte", captured[w + 1].isData, 1'b1);
            comparePixel("panel pixel", capturedPixel(k), expectedPixels[k]);
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore)
        begin
            testsPassed++;
            $display("Test %s: ok", name);
        end
        else
        begin
            testsFailed++;
            $display("Test %s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task automatic testResetInit();
        int errorsBefore;
        int k;
        errorsBefore = errorCount;
        repeat (10)
        begin
            @(negedge aclk);
            compareBit("cs during reset", cs, 1'b1);
            compareBit("wr during reset", wr, 1'b1);
            compareBit("dc during reset", dc, 1'b1);
            compareBit("sReady during reset", sReady, 1'b0);
        end
        resetn = 1'b1;
        @(negedge aclk);
        compareBit("cs after reset", cs, 1'b0);
        // Pixels offered while the init table is still going out
        for (k = 0; k < 3; k++)
            sendPixel(nextRandom());
        sValid = 1'b0;
        waitForBytes(initLength);
        for (k = 0; k < initLength; k++)
            compareWord($sformatf("init word %0d", k), captured[k], initTablePortrait[k]);
        checkPixels(0, 3);
        finishTest("reset and init sequence", errorsBefore);
    endtask

    task automatic testRgb565();
        int errorsBefore;
        int first;
        errorsBefore = errorCount;
        first = expectedPixels.size();
        format = formatRgb565Reversed;
        repeat (8)
            sendPixel(nextRandom());
        sValid = 1'b0;
        checkPixels(first, 8);
        finishTest("RGB565 reversed format", errorsBefore);
    endtask

    task automatic testRgba4444();
        int       errorsBefore;
        int       first;
        pixelIn_t pix;
        errorsBefore = errorCount;
        first = expectedPixels.size();
        format = formatRgba4444;
        repeat (6)
            sendPixel(nextRandom());
        // Last two pixels differ only in the alpha nibble
        pix = nextRandom();
        sendPixel(pix);
        sendPixel({pix[15:4], ~pix[3:0]});
        sValid = 1'b0;
        checkPixels(first, 8);
        comparePixel("alpha independence", capturedPixel(first + 7), capturedPixel(first + 6));
        finishTest("RGBA4444 format", errorsBefore);
    endtask

    task automatic testBurst();
        int errorsBefore;
        int first;
        int byteStart;
        int k;
        errorsBefore = errorCount;
        first = expectedPixels.size();
        byteStart = initLength + 2 * first;
        stallSeen = 1'b0;
        repeat (20)
            sendPixel(nextRandom());
        sValid = 1'b0;
        checkPixels(first, 20);
        // Quiet period so that a repeated byte would still show up
        repeat (50) @(negedge aclk);
        compareCount("bytes per accepted pixel", captured.size() - initLength,
                     2 * expectedPixels.size());
        if (!stallSeen)
        begin
            errorCount++;
            $display("sReady never dropped while the bus was busy");
        end
        for (k = byteStart; k < byteStart + 39; k++)
            compareCount("burst byte period", fallGap[k], bytePeriod);
        finishTest("back-pressure and order", errorsBefore);
    endtask

    task automatic testStrobeTiming();
        int errorsBefore;
        int k;
        int commandCount;
        int dcLowCount;
        errorsBefore = errorCount;
        commandCount = 0;
        dcLowCount = 0;
        foreach (lowLength[k])
            compareCount("wr low phase", lowLength[k], strobePhase);
        for (k = 0; k < initLength - 1; k++)
            compareCount("init byte period", fallGap[k], bytePeriod);
        foreach (fallGap[k])
        begin
            if (fallGap[k] < bytePeriod)
            begin
                errorCount++;
                $display("wr fell again before a full byte period at byte %0d", k + 1);
            end
        end
        compareCount("strobes with cs high", csHighStrobes, 0);
        for (k = 0; k < initLength; k++)
            if (!initTablePortrait[k].isData)
                commandCount++;
        foreach (captured[k])
            if (!captured[k].isData)
                dcLowCount++;
        compareCount("bytes with dc low", dcLowCount, commandCount);
        finishTest("strobe timing", errorsBefore);
    endtask

    initial
    begin
        aclk = 1'b0;
        resetn = 1'b0;
        format = formatRgb565Reversed;
        sValid = 1'b0;
        sPixel = '0;
        errorCount = 0;
        testsPassed = 0;
        testsFailed = 0;
        stallSeen = 1'b0;
        lcgState = 32'd7477;
        testResetInit();
        testRgb565();
        testRgba4444();
        testBurst();
        testStrobeTiming();
        $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && errorCount == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+verif
source/displayTypesPkg.sv
source/pixelTypesPkg.sv
source/streamSlice.sv
source/pixelConverter.sv
source/commandSequencer.sv
source/parallelBusWriter.sv
source/displayController.sv
verif/displayControllerTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the display controller testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f all.f \
    --top-module displayControllerTb -o displayControllerTb \
    && ./obj_dir/displayControllerTb | tee /dev/stderr | grep "TB PASSED" > /dev/null \
    && echo "Simulation finished without errors" \
    || { echo "Simulation reported failure"; exit 1; }
